//--- bench/pea_chk.sv
// ====================
// concurrent checks on the actor strobes, bound into pea_top
// ====================
module pea_chk (
    input logic clk,
    input logic reset,
    input logic start,
    input logic idle,
    input logic fire_complete,
    input logic cmd_rd_en,
    input logic data_rd_en,
    input logic [pea_pkg::pop_width-1:0] cmd_pop,
    input logic [pea_pkg::pop_width-1:0] data_pop
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // start is a single-cycle pulse
    start_pulse: assert property (@(posedge clk) disable iff (reset) start |=> !start)
        else
        begin
            fail_count++;
            $error("start held for more than one cycle");
        end

    // completion only arrives while a firing is open
    complete_busy: assert property (@(posedge clk) disable iff (reset)
        fire_complete |-> !idle)
        else
        begin
            fail_count++;
            $error("fire_complete while the actor is idle");
        end

    // no pop from an empty fifo
    cmd_pop_ok: assert property (@(posedge clk) disable iff (reset)
        cmd_rd_en |-> (cmd_pop != '0))
        else
        begin
            fail_count++;
            $error("command read with empty command fifo");
        end

    data_pop_ok: assert property (@(posedge clk) disable iff (reset)
        data_rd_en |-> (data_pop != '0))
        else
        begin
            fail_count++;
            $error("data read with empty data fifo");
        end

endmodule

bind pea_top pea_chk pea_chk_inst (
    .clk(clk), .reset(reset),
    .start(actor_inst.start), .idle(actor_idle), .fire_complete(fire_complete),
    .cmd_rd_en(cmd_rd_en), .data_rd_en(data_rd_en),
    .cmd_pop(cmd_pop), .data_pop(data_pop)
);

//--- bench/pea_tb.sv
// ====================
// table-driven testbench for pea_top, with a reference model checking output tokens in order
// ====================
module pea_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // one row of the stimulus table
    typedef struct packed {
        logic [7:0] op;
        logic [2:0] shift;
        logic [4:0] count;
        logic [5:0] ndata;
        logic [1:0] dmode;
        int stall;
        int lag;
    } test_t;

    localparam int num_tests = 20;
    localparam int cycle_limit = num_tests * 64;

    logic clk;
    logic reset;
    logic cmd_valid;
    logic cmd_ready;
    pea_pkg::pea_cmd_t cmd_token;
    logic data_valid;
    logic data_ready;
    logic signed [pea_pkg::data_width-1:0] data_token;
    logic out_valid;
    logic out_ready;
    pea_pkg::pea_out_t out_token;

    test_t tests [num_tests];
    pea_pkg::pea_out_t expected [num_tests];
    logic signed [pea_pkg::data_width-1:0] data_vals [$];
    logic [31:0] lcg_state;
    int out_idx;
    int passed;
    int errors;
    int cycles;

    pea_top pea_top_inst (
        .clk(clk), .reset(reset),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_token(cmd_token),
        .data_valid(data_valid), .data_ready(data_ready), .data_token(data_token),
        .out_valid(out_valid), .out_ready(out_ready), .out_token(out_token)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // data tokens in send order, dmode 1 forces negatives, dmode 2 is the most negative value
    task automatic make_data();
        logic [31:0] rnd;
        logic signed [pea_pkg::data_width-1:0] v;
        for (int i = 0; i < num_tests; i++)
        begin
            for (int j = 0; j < tests[i].ndata; j++)
            begin
                rnd = lcg_next();
                v = rnd[31:16];
                if (tests[i].dmode == 2'd1)
                    v[15] = 1'b1;
                else if (tests[i].dmode == 2'd2)
                    v = 16'sh8000;
                data_vals.push_back(v);
            end
        end
    endtask

    // reference model, commands consume the shared data stream in order
    task automatic build_expected();
        int didx;
        int need;
        logic signed [31:0] acc;
        logic signed [31:0] v;
        pea_pkg::pea_status_e st;
        didx = 0;
        for (int i = 0; i < num_tests; i++)
        begin
            need = 0;
            acc = 0;
            st = pea_pkg::ST_OK;
            case (tests[i].op)
                pea_pkg::OP_CLR: need = 0;
                pea_pkg::OP_SUM, pea_pkg::OP_MAX:
                begin
                    need = tests[i].count;
                    if (need == 0)
                        st = pea_pkg::ST_ZERO_LEN;
                end
                pea_pkg::OP_MUL: need = 2;
                default: st = pea_pkg::ST_BAD_OP;
            endcase
            for (int k = 0; k < need; k++)
            begin
                v = data_vals[didx + k];
                if (tests[i].op == pea_pkg::OP_SUM)
                    acc = acc + v;
                else if (tests[i].op == pea_pkg::OP_MAX)
                    acc = (k == 0 || v > acc) ? v : acc;
                else
                    acc = (k == 0) ? v : acc * v;
            end
            didx += need;
            expected[i].status = st;
            expected[i].result = acc >>> tests[i].shift;
        end
    endtask

    task automatic drive_commands();
        for (int i = 0; i < num_tests; i++)
        begin
            // negative lag holds the command back so its data gets ahead
            if (tests[i].lag < 0)
                repeat (-tests[i].lag) @(negedge clk);
            cmd_token.opcode = tests[i].op;
            cmd_token.arg1 = tests[i].shift;
            cmd_token.arg2 = tests[i].count;
            cmd_valid = 1'b1;
            // ready is settled at the falling edge, transfer lands on the next rising edge
            while (!cmd_ready)
                @(negedge clk);
            @(negedge clk);
            cmd_valid = 1'b0;
        end
    endtask

    task automatic drive_data();
        int d;
        d = 0;
        for (int i = 0; i < num_tests; i++)
        begin
            // positive lag lets the command arrive well before its data
            if (tests[i].lag > 0)
                repeat (tests[i].lag) @(negedge clk);
            for (int j = 0; j < tests[i].ndata; j++)
            begin
                data_token = data_vals[d];
                data_valid = 1'b1;
                while (!data_ready)
                    @(negedge clk);
                @(negedge clk);
                data_valid = 1'b0;
                d++;
            end
        end
    endtask

    task automatic check_output();
        if (out_idx >= num_tests)
        begin
            errors++;
            $display("extra output token after the last command at %0t", $time);
        end
        else
        begin
            if (out_token !== expected[out_idx])
            begin
                errors++;
                $display("FAIL @%0t test %0d: got status %0d result %0d, expected %0d %0d",
                         $time, out_idx, out_token.status, out_token.result,
                         expected[out_idx].status, expected[out_idx].result);
            end
            else
            begin
                passed++;
                $display("test %0d done: op %h status %0d result %0d", out_idx,
                         tests[out_idx].op, out_token.status, out_token.result);
            end
            out_idx++;
        end
    endtask

    // out_ready per test, then accept and check while valid and ready hold
    initial
    begin
        int held;
        int last_idx;
        logic [31:0] rnd;
        held = 0;
        last_idx = -1;
        @(negedge reset);
        forever
        begin
            @(negedge clk);
            if (out_idx != last_idx)
            begin
                held = 0;
                last_idx = out_idx;
            end
            if (out_idx >= num_tests)
                out_ready = 1'b1;
            else if (tests[out_idx].stall < 0)
            begin
                rnd = lcg_next();
                out_ready = rnd[31];
            end
            else if (held < tests[out_idx].stall)
            begin
                out_ready = 1'b0;
                held++;
            end
            else
                out_ready = 1'b1;
            if (out_valid && out_ready)
                check_output();
        end
    end

    // run limit scales with the table
    initial
    begin
        cycles = 0;
        while (cycles <= cycle_limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: only %0d of %0d outputs after %0d cycles",
                 out_idx, num_tests, cycles);
        $display("TESTS FAILED");
        $finish;
    end

    initial
    begin
        reset = 1'b1;
        cmd_valid = 1'b0;
        cmd_token = '0;
        data_valid = 1'b0;
        data_token = '0;
        out_ready = 1'b0;
        out_idx = 0;
        passed = 0;
        errors = 0;
        lcg_state = 32'h2c5e_e80a;
        // op, shift, count, ndata, dmode, stall, lag
        // row 0 stalls long so the output fifo fills behind it
        // row 1 command arrives after its data, row 14 data after its command
        // CLR, zero count and bad op send data that the next row consumes
        tests = '{
            '{8'h01, 3'd0, 5'd1, 6'd1, 2'd0, 250, 0},
            '{8'h01, 3'd3, 5'd5, 6'd5, 2'd0, 0, -10},
            '{8'h01, 3'd0, 5'd31, 6'd31, 2'd0, 0, 0},
            '{8'h01, 3'd3, 5'd31, 6'd31, 2'd0, 0, 0},
            '{8'h02, 3'd0, 5'd4, 6'd4, 2'd1, 0, 0},
            '{8'h02, 3'd2, 5'd6, 6'd6, 2'd0, 0, 0},
            '{8'h03, 3'd0, 5'd0, 6'd2, 2'd2, 0, 0},
            '{8'h03, 3'd1, 5'd0, 6'd2, 2'd0, 0, 0},
            '{8'h00, 3'd0, 5'd0, 6'd3, 2'd0, 0, 0},
            '{8'h01, 3'd0, 5'd3, 6'd0, 2'd0, 0, 0},
            '{8'h01, 3'd0, 5'd0, 6'd2, 2'd1, 0, 0},
            '{8'h02, 3'd0, 5'd2, 6'd0, 2'd0, 0, 0},
            '{8'h7f, 3'd0, 5'd4, 6'd1, 2'd0, 0, 0},
            '{8'h03, 3'd0, 5'd0, 6'd1, 2'd0, 0, 0},
            '{8'h01, 3'd1, 5'd4, 6'd4, 2'd0, 0, 12},
            '{8'h02, 3'd0, 5'd3, 6'd3, 2'd1, 0, 0},
            '{8'h01, 3'd0, 5'd2, 6'd2, 2'd0, -1, 0},
            '{8'h03, 3'd2, 5'd0, 6'd2, 2'd0, -1, 0},
            '{8'h00, 3'd0, 5'd0, 6'd0, 2'd0, -1, 0},
            '{8'h02, 3'd3, 5'd5, 6'd5, 2'd0, -1, 0}
        };
        make_data();
        build_expected();
        repeat (16) @(negedge clk);
        reset = 1'b0;
        fork
            drive_commands();
            drive_data();
        join
        while (out_idx < num_tests)
            @(negedge clk);
        // quiet period catches any token beyond one per command
        repeat (8) @(negedge clk);
        errors += pea_top_inst.pea_chk_inst.fail_count;
        $display("%0d of %0d tests matched, %0d errors", passed, num_tests, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- hw/pea_actor.sv
// ====================
// invoke controller, one start pulse per invoke, reports idle and completion
// ====================
module pea_actor (
    input logic clk,
    input logic reset,
    input logic invoke,
    input pea_pkg::pea_cmd_t cmd_head,
    input logic signed [pea_pkg::data_width-1:0] data_head,
    output logic cmd_rd_en,
    output logic data_rd_en,
    output logic out_wr_en,
    output pea_pkg::pea_out_t out_token,
    output logic idle,
    output logic fire_complete
);

    pea_pkg::actor_state_e state;
    logic start;
    logic done;

    // start only lives in FIRING_START, so it is one cycle wide
    assign start = (state == pea_pkg::FIRING_START);
    assign idle = (state == pea_pkg::ACT_IDLE);
    assign fire_complete = done;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= pea_pkg::ACT_IDLE;
        end
        else
        begin
            unique case (state)
                pea_pkg::ACT_IDLE: if (invoke) state <= pea_pkg::FIRING_START;
                pea_pkg::FIRING_START: state <= pea_pkg::FIRING_WAIT;
                // back to idle the edge after done
                pea_pkg::FIRING_WAIT: if (done) state <= pea_pkg::ACT_IDLE;
                default: state <= pea_pkg::ACT_IDLE;
            endcase
        end
    end

    pea_firing_fsm firing_fsm_inst (
        .clk(clk),
        .reset(reset),
        .start(start),
        .cmd_head(cmd_head),
        .data_head(data_head),
        .cmd_rd_en(cmd_rd_en),
        .data_rd_en(data_rd_en),
        .out_wr_en(out_wr_en),
        .out_token(out_token),
        .done(done)
    );

endmodule

//--- hw/pea_enable.sv
// ====================
// firing rule, combinational
// checks head command, data on hand and room for the result
// ====================
module pea_enable (
    input pea_pkg::pea_cmd_t cmd_head,
    input logic [pea_pkg::pop_width-1:0] cmd_pop,
    input logic [pea_pkg::pop_width-1:0] data_pop,
    input logic [pea_pkg::pop_width-1:0] out_free,
    output logic can_fire
);

    logic [4:0] need;
    logic [pea_pkg::pop_width-1:0] need_cap;
    logic cmd_present;
    logic data_ok;
    logic room_ok;

    // tokens the head command will read
    assign need = pea_pkg::data_need(cmd_head);

    // a count above the fifo depth can never be fully buffered
    // so a full data fifo is enough, the rest streams in behind it
    always_comb
    begin
        if (need > pea_pkg::fifo_depth)
        begin
            need_cap = pea_pkg::pop_width'(pea_pkg::fifo_depth);
        end
        else
        begin
            need_cap = pea_pkg::pop_width'(need);
        end
    end

    // head is only meaningful when the command fifo holds something
    assign cmd_present = (cmd_pop != '0);
    assign data_ok = (data_pop >= need_cap);
    // one output slot reserved for the whole firing
    assign room_ok = (out_free != '0);

    assign can_fire = cmd_present && data_ok && room_ok;

endmodule

//--- hw/pea_firing_fsm.sv
// ====================
// one firing: pop the command, stream its data, push one output token
// ====================
module pea_firing_fsm (
    input logic clk,
    input logic reset,
    input logic start,
    input pea_pkg::pea_cmd_t cmd_head,
    input logic signed [pea_pkg::data_width-1:0] data_head,
    output logic cmd_rd_en,
    output logic data_rd_en,
    output logic out_wr_en,
    output pea_pkg::pea_out_t out_token,
    output logic done
);

    pea_pkg::fsm_state_e state;
    pea_pkg::pea_cmd_t cmd_q;
    pea_pkg::pea_status_e status_q;
    logic signed [pea_pkg::result_width-1:0] acc_q;
    logic [4:0] cnt;
    logic first_q;

    // strobes follow the state directly
    assign cmd_rd_en = (state == pea_pkg::FETCH_CMD);
    assign data_rd_en = (state == pea_pkg::READ_DATA);
    assign out_wr_en = (state == pea_pkg::WRITE_OUT);
    assign done = (state == pea_pkg::WRITE_OUT);

    // arg1 shift applied on the way out
    assign out_token.status = status_q;
    assign out_token.result = acc_q >>> cmd_q.arg1;

    // control
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= pea_pkg::FSM_IDLE;
            cnt <= '0;
            first_q <= 1'b0;
        end
        else
        begin
            unique case (state)
                pea_pkg::FSM_IDLE:
                begin
                    if (start)
                    begin
                        state <= pea_pkg::FETCH_CMD;
                    end
                end
                pea_pkg::FETCH_CMD:
                begin
                    cnt <= pea_pkg::data_need(cmd_q);
                    first_q <= 1'b1;
                    // nothing to read goes straight to the write
                    if (pea_pkg::data_need(cmd_q) == '0)
                        state <= pea_pkg::WRITE_OUT;
                    else
                        state <= pea_pkg::READ_DATA;
                end
                pea_pkg::READ_DATA:
                begin
                    cnt <= cnt - 1'b1;
                    first_q <= 1'b0;
                    if (cnt == 5'd1)
                    begin
                        state <= pea_pkg::WRITE_OUT;
                    end
                end
                pea_pkg::WRITE_OUT:
                begin
                    state <= pea_pkg::FSM_IDLE;
                end
                default: state <= pea_pkg::FSM_IDLE;
            endcase
        end
    end

    // payload: command, status and running result
    always_ff @(posedge clk)
    begin
        // head still shows the command here, it is popped in FETCH_CMD
        if (state == pea_pkg::FSM_IDLE && start)
        begin
            cmd_q <= cmd_head;
        end
        if (state == pea_pkg::FETCH_CMD)
        begin
            acc_q <= '0;
            case (cmd_q.opcode)
                pea_pkg::OP_CLR: status_q <= pea_pkg::ST_OK;
                pea_pkg::OP_MUL: status_q <= pea_pkg::ST_OK;
                pea_pkg::OP_SUM, pea_pkg::OP_MAX:
                    status_q <= (cmd_q.arg2 == '0) ? pea_pkg::ST_ZERO_LEN : pea_pkg::ST_OK;
                default: status_q <= pea_pkg::ST_BAD_OP;
            endcase
        end
        if (state == pea_pkg::READ_DATA)
        begin
            case (cmd_q.opcode)
                pea_pkg::OP_SUM: acc_q <= acc_q + data_head;
                // first token seeds the maximum
                pea_pkg::OP_MAX: if (first_q || data_head > acc_q) acc_q <= data_head;
                // 16 by 16 product always fits in 32 bits
                pea_pkg::OP_MUL: acc_q <= first_q ? 32'(data_head) : acc_q * data_head;
                default: acc_q <= acc_q;
            endcase
        end
    end

endmodule

//--- hw/pea_pkg.sv
// ====================
// shared types and sizes for the PEA actor
// referenced by scoped name from every RTL file
// ====================
package pea_pkg;

    // token and fifo sizes
    localparam int data_width = 16;
    localparam int result_width = 32;
    localparam int fifo_depth = 16;
    localparam int fifo_addr_width = $clog2(fifo_depth);
    // a count must be able to hold the full depth
    localparam int pop_width = $clog2(fifo_depth) + 1;

    // command opcodes, anything else is rejected as BAD_OP
    typedef enum logic [7:0] {
        OP_CLR = 8'h00,
        OP_SUM = 8'h01,
        OP_MAX = 8'h02,
        OP_MUL = 8'h03
    } pea_opcode_e;

    // one status code per output token
    typedef enum logic [7:0] {
        ST_OK = 8'h00,
        ST_ZERO_LEN = 8'h01,
        ST_BAD_OP = 8'h02
    } pea_status_e;

    // opcode kept as raw bits so unknown codes survive decode
    typedef struct packed {
        logic [7:0] opcode;
        logic [2:0] arg1;
        logic [4:0] arg2;
    } pea_cmd_t;

    typedef struct packed {
        pea_status_e status;
        logic signed [result_width-1:0] result;
    } pea_out_t;

    typedef enum logic [1:0] {FSM_IDLE, FETCH_CMD, READ_DATA, WRITE_OUT} fsm_state_e;

    typedef enum logic [1:0] {ACT_IDLE, FIRING_START, FIRING_WAIT} actor_state_e;

    // number of data tokens a command consumes
    // zero counts, CLR and unknown opcodes read nothing
    function automatic logic [4:0] data_need(input pea_cmd_t cmd);
        case (cmd.opcode)
            OP_SUM, OP_MAX: return cmd.arg2;
            OP_MUL: return 5'd2;
            default: return 5'd0;
        endcase
    endfunction

endpackage

//--- hw/pea_top.sv
// ====================
// PEA top level: token FIFOs, firing rule, actor and a local always-invoke scheduler
// ====================
module pea_top (
    input logic clk,
    input logic reset,
    input logic cmd_valid,
    output logic cmd_ready,
    input pea_pkg::pea_cmd_t cmd_token,
    input logic data_valid,
    output logic data_ready,
    input logic signed [pea_pkg::data_width-1:0] data_token,
    output logic out_valid,
    input logic out_ready,
    output pea_pkg::pea_out_t out_token
);

    pea_pkg::pea_cmd_t cmd_head;
    logic signed [pea_pkg::data_width-1:0] data_head;
    pea_pkg::pea_out_t res_token;
    logic [pea_pkg::pop_width-1:0] cmd_pop, cmd_free;
    logic [pea_pkg::pop_width-1:0] data_pop, data_free;
    logic [pea_pkg::pop_width-1:0] out_pop, out_free;
    logic cmd_rd_en, data_rd_en, out_wr_en;
    logic can_fire, actor_idle, invoke, fire_complete;

    // external handshakes map onto fifo free and population
    assign cmd_ready = (cmd_free != '0);
    assign data_ready = (data_free != '0);
    assign out_valid = (out_pop != '0);

    // fire whenever the rule holds and the actor is free
    assign invoke = can_fire && actor_idle;

    token_fifo #(.width($bits(pea_pkg::pea_cmd_t))) cmd_fifo_inst (
        .clk(clk), .reset(reset),
        .wr_en(cmd_valid && cmd_ready), .wr_data(cmd_token),
        .rd_en(cmd_rd_en), .head(cmd_head), .pop(cmd_pop), .free(cmd_free)
    );

    token_fifo #(.width(pea_pkg::data_width)) data_fifo_inst (
        .clk(clk), .reset(reset),
        .wr_en(data_valid && data_ready), .wr_data(data_token),
        .rd_en(data_rd_en), .head(data_head), .pop(data_pop), .free(data_free)
    );

    // output fifo pops on a completed external transfer
    token_fifo #(.width($bits(pea_pkg::pea_out_t))) out_fifo_inst (
        .clk(clk), .reset(reset),
        .wr_en(out_wr_en), .wr_data(res_token),
        .rd_en(out_valid && out_ready), .head(out_token), .pop(out_pop), .free(out_free)
    );

    pea_enable enable_inst (
        .cmd_head(cmd_head), .cmd_pop(cmd_pop), .data_pop(data_pop),
        .out_free(out_free), .can_fire(can_fire)
    );

    pea_actor actor_inst (
        .clk(clk), .reset(reset), .invoke(invoke),
        .cmd_head(cmd_head), .data_head(data_head),
        .cmd_rd_en(cmd_rd_en), .data_rd_en(data_rd_en),
        .out_wr_en(out_wr_en), .out_token(res_token),
        .idle(actor_idle), .fire_complete(fire_complete)
    );

endmodule

//--- hw/token_fifo.sv
// ====================
// first-word-fall-through token FIFO with population and free-space counts
// ====================
module token_fifo #(
    parameter int width = pea_pkg::data_width
) (
    input logic clk,
    input logic reset,
    input logic wr_en,
    input logic [width-1:0] wr_data,
    input logic rd_en,
    output logic [width-1:0] head,
    output logic [pea_pkg::pop_width-1:0] pop,
    output logic [pea_pkg::pop_width-1:0] free
);

    logic [width-1:0] mem [pea_pkg::fifo_depth];
    logic [pea_pkg::fifo_addr_width-1:0] wr_ptr;
    logic [pea_pkg::fifo_addr_width-1:0] rd_ptr;
    logic [pea_pkg::pop_width-1:0] count;
    logic do_wr;
    logic do_rd;

    // requests past full or empty are dropped
    assign do_wr = wr_en && (count != pea_pkg::pop_width'(pea_pkg::fifo_depth));
    assign do_rd = rd_en && (count != '0);

    // oldest word is always on head, no read needed
    assign head = mem[rd_ptr];
    assign pop = count;
    assign free = pea_pkg::pop_width'(pea_pkg::fifo_depth) - count;

    // storage
    always_ff @(posedge clk)
    begin
        if (do_wr)
        begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_wr)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            if (do_wr && !do_rd)
            begin
                count <= count + 1'b1;
            end
            else if (do_rd && !do_wr)
            begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run the PEA testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f sources.f --top-module pea_tb -o pea_sim

out=$(./obj_dir/pea_sim)
echo "$out"
echo "$out" | grep -q "^TESTS PASSED$"

//--- sources.f
hw/pea_pkg.sv
hw/token_fifo.sv
hw/pea_enable.sv
hw/pea_firing_fsm.sv
hw/pea_actor.sv
hw/pea_top.sv
bench/pea_chk.sv
bench/pea_tb.sv
